// ==== cl_periph_pkg.sv ====
/* Widths, register bus structs, target map, interrupt source positions
   and register offsets of the core-local peripherals */
`default_nettype none

package cl_periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  reg_off_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic  valid;
    logic  error;
    data_t rdata;
  } reg_rsp_t;

  // Request as seen by one target, offset local to its window
  typedef struct packed {
    logic     valid;
    logic     write;
    reg_off_t off;
    data_t    wdata;
  } tgt_req_t;

  typedef enum logic [1:0] {
    TgtInstrErr,
    TgtDataErr,
    TgtIrq,
    TgtNone
  } tgt_sel_e;

  localparam data_t ErrVal = 32'hBADCAB1E;

  // Target windows relative to the peripheral base
  localparam addr_t InstrErrOffset = 32'h0000_0000;
  localparam addr_t DataErrOffset  = 32'h0000_0100;
  localparam addr_t IrqOffset      = 32'h0000_0200;
  localparam addr_t TgtRange       = 32'h0000_0100;

  localparam int unsigned NumSources = 32;
  typedef logic [$clog2(NumSources)-1:0] irq_id_t;

  localparam int unsigned TimerIrqIdx    = 16;
  localparam int unsigned InstrErrIrqIdx = 18;
  localparam int unsigned DataErrIrqIdx  = 19;
  localparam int unsigned ExtIrqBase     = 24;

  localparam reg_off_t ErrAddrReg   = 8'h00;
  localparam reg_off_t ErrCodeReg   = 8'h04;
  localparam reg_off_t ErrStatusReg = 8'h08;

  localparam reg_off_t IrqEnableReg  = 8'h00;
  localparam reg_off_t IrqPendingReg = 8'h04;
  localparam reg_off_t IrqIdReg      = 8'h08;

endpackage

`default_nettype wire

// ==== cl_periph_decode.sv ====
/* Register bus decoder: window match, per-target request strobes
   and the registered one-cycle response */
`timescale 1ns/1ps
`default_nettype none

module cl_periph_decode #(
  parameter cl_periph_pkg::addr_t PeriphBaseAddr = 32'h0020_0000
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  cl_periph_pkg::reg_req_t reg_req_i,
  output cl_periph_pkg::reg_rsp_t reg_rsp_o,
  output cl_periph_pkg::tgt_req_t instr_req_o,
  output cl_periph_pkg::tgt_req_t data_req_o,
  output cl_periph_pkg::tgt_req_t irq_req_o,
  input  cl_periph_pkg::data_t    instr_rdata_i,
  input  cl_periph_pkg::data_t    data_rdata_i,
  input  cl_periph_pkg::data_t    irq_rdata_i
);

  cl_periph_pkg::addr_t    rel_addr;
  cl_periph_pkg::addr_t    tgt_base;
  cl_periph_pkg::tgt_sel_e sel;
  cl_periph_pkg::tgt_req_t tgt_req;
  cl_periph_pkg::data_t    sel_rdata;

  logic                 rsp_valid_q;
  logic                 rsp_error_q;
  cl_periph_pkg::data_t rsp_rdata_q;

  function automatic logic in_window(cl_periph_pkg::addr_t addr, cl_periph_pkg::addr_t base);
    return (addr >= base) && ((addr - base) < cl_periph_pkg::TgtRange);
  endfunction

  // Below the base this wraps to a large value and matches no window
  assign rel_addr = reg_req_i.addr - PeriphBaseAddr;

  always_comb begin
    sel      = cl_periph_pkg::TgtNone;
    tgt_base = '0;
    if (in_window(rel_addr, cl_periph_pkg::InstrErrOffset)) begin
      sel      = cl_periph_pkg::TgtInstrErr;
      tgt_base = cl_periph_pkg::InstrErrOffset;
    end else if (in_window(rel_addr, cl_periph_pkg::DataErrOffset)) begin
      sel      = cl_periph_pkg::TgtDataErr;
      tgt_base = cl_periph_pkg::DataErrOffset;
    end else if (in_window(rel_addr, cl_periph_pkg::IrqOffset)) begin
      sel      = cl_periph_pkg::TgtIrq;
      tgt_base = cl_periph_pkg::IrqOffset;
    end
  end

  assign tgt_req.valid = reg_req_i.valid;
  assign tgt_req.write = reg_req_i.write;
  assign tgt_req.off   = cl_periph_pkg::reg_off_t'(rel_addr - tgt_base);
  assign tgt_req.wdata = reg_req_i.wdata;

  // Only the selected target sees the strobe
  always_comb begin
    instr_req_o       = tgt_req;
    data_req_o        = tgt_req;
    irq_req_o         = tgt_req;
    instr_req_o.valid = tgt_req.valid && (sel == cl_periph_pkg::TgtInstrErr);
    data_req_o.valid  = tgt_req.valid && (sel == cl_periph_pkg::TgtDataErr);
    irq_req_o.valid   = tgt_req.valid && (sel == cl_periph_pkg::TgtIrq);
  end

  always_comb begin
    case (sel)
      cl_periph_pkg::TgtInstrErr: sel_rdata = instr_rdata_i;
      cl_periph_pkg::TgtDataErr:  sel_rdata = data_rdata_i;
      cl_periph_pkg::TgtIrq:      sel_rdata = irq_rdata_i;
      default:                    sel_rdata = cl_periph_pkg::ErrVal;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= reg_req_i.valid;
    end
  end

  // Read data sampled on the request edge, before a write lands
  always_ff @(posedge clk_i) begin
    if (reg_req_i.valid) begin
      rsp_error_q <= (sel == cl_periph_pkg::TgtNone);
      rsp_rdata_q <= sel_rdata;
    end
  end

  assign reg_rsp_o.valid = rsp_valid_q;
  assign reg_rsp_o.error = rsp_error_q;
  assign reg_rsp_o.rdata = rsp_rdata_q;

  a_one_target: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({instr_req_o.valid, data_req_o.valid, irq_req_o.valid}));

endmodule

`default_nettype wire

// ==== obi_err_unit.sv ====
/* OBI bus error unit: outstanding address tracking, error queue
   with overflow flag, and its status registers */
`timescale 1ns/1ps
`default_nettype none

module obi_err_unit #(
  parameter int unsigned NumBusErrBits   = 2,
  parameter int unsigned NumOutstanding  = 2,
  parameter int unsigned NumStoredErrors = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    obi_req_i,
  input  logic                    obi_gnt_i,
  input  logic                    obi_rvalid_i,
  input  cl_periph_pkg::addr_t    obi_addr_i,
  input  logic [NumBusErrBits-1:0] obi_err_i,
  input  cl_periph_pkg::tgt_req_t tgt_req_i,
  output cl_periph_pkg::data_t    rdata_o,
  output logic                    err_irq_o
);

  localparam int unsigned OutPtrW = (NumOutstanding > 1) ? $clog2(NumOutstanding) : 1;
  localparam int unsigned OutCntW = $clog2(NumOutstanding + 1);
  localparam int unsigned ErrPtrW = (NumStoredErrors > 1) ? $clog2(NumStoredErrors) : 1;
  localparam int unsigned ErrCntW = $clog2(NumStoredErrors + 1);

  typedef struct packed {
    cl_periph_pkg::addr_t     addr;
    logic [NumBusErrBits-1:0] code;
  } err_entry_t;

  cl_periph_pkg::addr_t out_mem [NumOutstanding];
  logic [OutPtrW-1:0]   out_wr_q;
  logic [OutPtrW-1:0]   out_rd_q;
  logic [OutCntW-1:0]   out_cnt_q;
  logic                 out_push;
  logic                 out_pop;

  err_entry_t           err_mem [NumStoredErrors];
  logic [ErrPtrW-1:0]   err_wr_q;
  logic [ErrPtrW-1:0]   err_rd_q;
  logic [ErrCntW-1:0]   err_cnt_q;
  logic                 ovf_q;
  logic                 err_push;
  logic                 err_store;
  logic                 err_pop;
  logic                 status_wr;
  logic                 err_nonempty;
  err_entry_t           head;

  function automatic int unsigned wrap_inc(int unsigned ptr, int unsigned depth);
    return (ptr + 1 == depth) ? 0 : ptr + 1;
  endfunction

  // Outstanding address FIFO, in-order responses pop the oldest
  assign out_pop  = obi_rvalid_i && (out_cnt_q != '0);
  assign out_push = obi_req_i && obi_gnt_i &&
                    ((out_cnt_q != OutCntW'(NumOutstanding)) || out_pop);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_wr_q  <= '0;
      out_rd_q  <= '0;
      out_cnt_q <= '0;
    end else begin
      if (out_push) begin
        out_wr_q <= OutPtrW'(wrap_inc(out_wr_q, NumOutstanding));
      end
      if (out_pop) begin
        out_rd_q <= OutPtrW'(wrap_inc(out_rd_q, NumOutstanding));
      end
      if (out_push && !out_pop) begin
        out_cnt_q <= out_cnt_q + 1'b1;
      end else if (out_pop && !out_push) begin
        out_cnt_q <= out_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_push) begin
      out_mem[out_wr_q] <= obi_addr_i;
    end
  end

  // Error queue, newest entry dropped when full
  assign err_push  = out_pop && (obi_err_i != '0);
  assign status_wr = tgt_req_i.valid && tgt_req_i.write &&
                     (tgt_req_i.off == cl_periph_pkg::ErrStatusReg);
  assign err_pop   = status_wr && err_nonempty;
  assign err_store = err_push && ((err_cnt_q != ErrCntW'(NumStoredErrors)) || err_pop);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_wr_q  <= '0;
      err_rd_q  <= '0;
      err_cnt_q <= '0;
      ovf_q     <= 1'b0;
    end else begin
      if (err_store) begin
        err_wr_q <= ErrPtrW'(wrap_inc(err_wr_q, NumStoredErrors));
      end
      if (err_pop) begin
        err_rd_q <= ErrPtrW'(wrap_inc(err_rd_q, NumStoredErrors));
      end
      if (err_store && !err_pop) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end else if (err_pop && !err_store) begin
        err_cnt_q <= err_cnt_q - 1'b1;
      end
      if (err_push && !err_store) begin
        ovf_q <= 1'b1;
      end else if (status_wr) begin
        ovf_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_store) begin
      err_mem[err_wr_q] <= '{addr: out_mem[out_rd_q], code: obi_err_i};
    end
  end

  assign err_nonempty = (err_cnt_q != '0);
  assign head         = err_mem[err_rd_q];
  assign err_irq_o    = err_nonempty;

  always_comb begin
    rdata_o = '0;
    case (tgt_req_i.off)
      cl_periph_pkg::ErrAddrReg: begin
        if (err_nonempty) begin
          rdata_o = head.addr;
        end
      end
      cl_periph_pkg::ErrCodeReg: begin
        if (err_nonempty) begin
          rdata_o[NumBusErrBits-1:0] = head.code;
        end
      end
      cl_periph_pkg::ErrStatusReg: begin
        rdata_o[31]  = ovf_q;
        rdata_o[7:0] = 8'(err_cnt_q);
      end
      default: ;
    endcase
  end

  // Every response must belong to an accepted request
  a_rvalid_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    obi_rvalid_i |-> (out_cnt_q != '0));

endmodule

`default_nettype wire

// ==== irq_ctrl.sv ====
/* Interrupt controller: edge capture, enable mask,
   highest-index selection and acknowledge */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [cl_periph_pkg::NumSources-1:0] src_i,
  input  cl_periph_pkg::tgt_req_t              tgt_req_i,
  output cl_periph_pkg::data_t                 rdata_o,
  output logic                                 irq_valid_o,
  output cl_periph_pkg::irq_id_t               irq_id_o,
  input  logic                                 irq_ack_i
);

  localparam int unsigned NumSrc = cl_periph_pkg::NumSources;
  localparam int unsigned IdW    = $bits(cl_periph_pkg::irq_id_t);

  logic [NumSrc-1:0] src_q;
  logic [NumSrc-1:0] pend_q;
  logic [NumSrc-1:0] pend_d;
  logic [NumSrc-1:0] en_q;
  logic [NumSrc-1:0] active;
  logic [NumSrc-1:0] rising;
  logic              en_wr;
  logic              pend_wr;

  assign en_wr   = tgt_req_i.valid && tgt_req_i.write &&
                   (tgt_req_i.off == cl_periph_pkg::IrqEnableReg);
  assign pend_wr = tgt_req_i.valid && tgt_req_i.write &&
                   (tgt_req_i.off == cl_periph_pkg::IrqPendingReg);

  assign rising      = src_i & ~src_q;
  assign active      = pend_q & en_q;
  assign irq_valid_o = |active;

  // Later index overrides, so the highest active source wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < NumSrc; i++) begin
      if (active[i]) begin
        irq_id_o = cl_periph_pkg::irq_id_t'(i);
      end
    end
  end

  // Clears first, so an edge on the same cycle still latches
  always_comb begin
    pend_d = pend_q;
    if (pend_wr) begin
      pend_d = pend_d & ~tgt_req_i.wdata[NumSrc-1:0];
    end
    if (irq_ack_i) begin
      pend_d[irq_id_o] = 1'b0;
    end
    pend_d = pend_d | rising;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q  <= '0;
      pend_q <= '0;
      en_q   <= '0;
    end else begin
      src_q  <= src_i;
      pend_q <= pend_d;
      if (en_wr) begin
        en_q <= tgt_req_i.wdata[NumSrc-1:0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (tgt_req_i.off)
      cl_periph_pkg::IrqEnableReg:  rdata_o[NumSrc-1:0] = en_q;
      cl_periph_pkg::IrqPendingReg: rdata_o[NumSrc-1:0] = pend_q;
      cl_periph_pkg::IrqIdReg:      rdata_o[IdW-1:0]    = irq_id_o;
      default: ;
    endcase
  end

  // The core only acknowledges what it was shown
  a_ack_while_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_ack_i |-> irq_valid_o);

endmodule

`default_nettype wire

// ==== safety_periph_top.sv ====
/* Core-local peripheral subsystem: decoder, two OBI error units
   and the interrupt controller with its source map */
`timescale 1ns/1ps
`default_nettype none

module safety_periph_top #(
  parameter cl_periph_pkg::addr_t PeriphBaseAddr  = 32'h0020_0000,
  parameter int unsigned          NumBusErrBits   = 2,
  parameter int unsigned          NumOutstanding  = 2,
  parameter int unsigned          NumStoredErrors = 8,
  // At most 8, the external lines sit in source bits 31:24
  parameter int unsigned          NumExtIrqs      = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  cl_periph_pkg::reg_req_t reg_req_i,
  output cl_periph_pkg::reg_rsp_t reg_rsp_o,

  input  logic                     instr_req_i,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  cl_periph_pkg::addr_t     instr_addr_i,
  input  logic [NumBusErrBits-1:0] instr_err_i,

  input  logic                     data_req_i,
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  input  cl_periph_pkg::addr_t     data_addr_i,
  input  logic [NumBusErrBits-1:0] data_err_i,

  input  logic                   timer_irq_i,
  input  logic [NumExtIrqs-1:0]  ext_irqs_i,
  input  logic                   irq_ack_i,
  output logic                   irq_valid_o,
  output cl_periph_pkg::irq_id_t irq_id_o
);

  cl_periph_pkg::tgt_req_t instr_tgt_req;
  cl_periph_pkg::tgt_req_t data_tgt_req;
  cl_periph_pkg::tgt_req_t irq_tgt_req;
  cl_periph_pkg::data_t    instr_rdata;
  cl_periph_pkg::data_t    data_rdata;
  cl_periph_pkg::data_t    irq_rdata;
  logic                    instr_err_irq;
  logic                    data_err_irq;

  logic [cl_periph_pkg::NumSources-1:0] irq_src;

  always_comb begin
    irq_src = '0;
    irq_src[cl_periph_pkg::TimerIrqIdx]                 = timer_irq_i;
    irq_src[cl_periph_pkg::InstrErrIrqIdx]              = instr_err_irq;
    irq_src[cl_periph_pkg::DataErrIrqIdx]               = data_err_irq;
    irq_src[cl_periph_pkg::ExtIrqBase +: NumExtIrqs]    = ext_irqs_i;
  end

  cl_periph_decode #(
    .PeriphBaseAddr ( PeriphBaseAddr )
  ) i_decode (
    .clk_i,
    .rst_i,
    .reg_req_i,
    .reg_rsp_o,
    .instr_req_o   ( instr_tgt_req ),
    .data_req_o    ( data_tgt_req  ),
    .irq_req_o     ( irq_tgt_req   ),
    .instr_rdata_i ( instr_rdata   ),
    .data_rdata_i  ( data_rdata    ),
    .irq_rdata_i   ( irq_rdata     )
  );

  obi_err_unit #(
    .NumBusErrBits   ( NumBusErrBits   ),
    .NumOutstanding  ( NumOutstanding  ),
    .NumStoredErrors ( NumStoredErrors )
  ) i_instr_err (
    .clk_i,
    .rst_i,
    .obi_req_i    ( instr_req_i    ),
    .obi_gnt_i    ( instr_gnt_i    ),
    .obi_rvalid_i ( instr_rvalid_i ),
    .obi_addr_i   ( instr_addr_i   ),
    .obi_err_i    ( instr_err_i    ),
    .tgt_req_i    ( instr_tgt_req  ),
    .rdata_o      ( instr_rdata    ),
    .err_irq_o    ( instr_err_irq  )
  );

  obi_err_unit #(
    .NumBusErrBits   ( NumBusErrBits   ),
    .NumOutstanding  ( NumOutstanding  ),
    .NumStoredErrors ( NumStoredErrors )
  ) i_data_err (
    .clk_i,
    .rst_i,
    .obi_req_i    ( data_req_i    ),
    .obi_gnt_i    ( data_gnt_i    ),
    .obi_rvalid_i ( data_rvalid_i ),
    .obi_addr_i   ( data_addr_i   ),
    .obi_err_i    ( data_err_i    ),
    .tgt_req_i    ( data_tgt_req  ),
    .rdata_o      ( data_rdata    ),
    .err_irq_o    ( data_err_irq  )
  );

  irq_ctrl i_irq_ctrl (
    .clk_i,
    .rst_i,
    .src_i       ( irq_src     ),
    .tgt_req_i   ( irq_tgt_req ),
    .rdata_o     ( irq_rdata   ),
    .irq_valid_o,
    .irq_id_o,
    .irq_ack_i
  );

endmodule

`default_nettype wire

// ==== tb_safety_periph.sv ====
/* Testbench of the peripheral subsystem: OBI slave models, register
   reference model, directed tests, response checker and watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_safety_periph;

  localparam cl_periph_pkg::addr_t Base      = 32'h0020_0000;
  localparam cl_periph_pkg::addr_t InstrBase = Base + cl_periph_pkg::InstrErrOffset;
  localparam cl_periph_pkg::addr_t DataBase  = Base + cl_periph_pkg::DataErrOffset;
  localparam cl_periph_pkg::addr_t IrqBase   = Base + cl_periph_pkg::IrqOffset;
  localparam int unsigned ErrBits       = 2;
  localparam int unsigned Depth         = 8;
  localparam int unsigned NumExt        = 8;
  localparam int unsigned NumTests      = 5;
  localparam int unsigned CyclesPerTest = 200;

  // Error queue entry {addr, code}
  typedef logic [31+ErrBits:0] entry_t;

  logic                    clk = 1'b0;
  logic                    rst;
  cl_periph_pkg::reg_req_t reg_req;
  cl_periph_pkg::reg_rsp_t reg_rsp;
  logic                    instr_req, instr_gnt, instr_rvalid;
  cl_periph_pkg::addr_t    instr_addr;
  logic [ErrBits-1:0]      instr_err;
  logic                    data_req, data_gnt, data_rvalid;
  cl_periph_pkg::addr_t    data_addr;
  logic [ErrBits-1:0]      data_err;
  logic                    timer_irq;
  logic [NumExt-1:0]       ext_irqs;
  logic                    irq_ack, irq_valid;
  cl_periph_pkg::irq_id_t  irq_id;

  // Reference model state
  entry_t      instr_q[$];
  entry_t      data_q[$];
  logic        instr_ovf, data_ovf;
  logic [31:0] pend_m, en_m;

  // Requests still waiting for their response
  logic [32:0]          exp_val[$];
  int                   exp_cyc[$];
  cl_periph_pkg::addr_t exp_addr[$];

  int     cyc = 0;
  int     err_count = 0;
  int     cmp_errs = 0;
  int     test_start_errs = 0;
  int     tests_failed = 0;
  string  cur_test = "reset";
  integer seed;

  safety_periph_top #(
    .PeriphBaseAddr  ( Base    ),
    .NumBusErrBits   ( ErrBits ),
    .NumOutstanding  ( 2       ),
    .NumStoredErrors ( Depth   ),
    .NumExtIrqs      ( NumExt  )
  ) safety_periph_top_i (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .reg_req_i      ( reg_req      ),
    .reg_rsp_o      ( reg_rsp      ),
    .instr_req_i    ( instr_req    ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_addr_i   ( instr_addr   ),
    .instr_err_i    ( instr_err    ),
    .data_req_i     ( data_req     ),
    .data_gnt_i     ( data_gnt     ),
    .data_rvalid_i  ( data_rvalid  ),
    .data_addr_i    ( data_addr    ),
    .data_err_i     ( data_err     ),
    .timer_irq_i    ( timer_irq    ),
    .ext_irqs_i     ( ext_irqs     ),
    .irq_ack_i      ( irq_ack      ),
    .irq_valid_o    ( irq_valid    ),
    .irq_id_o       ( irq_id       )
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic cl_periph_pkg::addr_t err_reg(logic is_data, cl_periph_pkg::reg_off_t off);
    return (is_data ? DataBase : InstrBase) + 32'(off);
  endfunction

  function automatic cl_periph_pkg::addr_t irq_reg(cl_periph_pkg::reg_off_t off);
    return IrqBase + 32'(off);
  endfunction

  // Highest enabled pending source
  function automatic logic [4:0] top_id();
    logic [31:0] act;
    logic [4:0]  id;
    act = pend_m & en_m;
    id  = '0;
    for (int i = 0; i < 32; i++) begin
      if (act[i]) id = 5'(i);
    end
    return id;
  endfunction

  // Expected {error, rdata} of a read under the register map
  function automatic logic [32:0] ref_read(cl_periph_pkg::addr_t addr);
    cl_periph_pkg::addr_t    rel;
    cl_periph_pkg::reg_off_t off;
    entry_t                  head;
    int                      n;
    logic                    ovf;
    logic [31:0]             rd;
    rel  = addr - Base;
    off  = rel[7:0];
    rd   = '0;
    head = '0;
    if (rel >= cl_periph_pkg::IrqOffset + cl_periph_pkg::TgtRange) begin
      return {1'b1, cl_periph_pkg::ErrVal};
    end
    if (rel >= cl_periph_pkg::IrqOffset) begin
      case (off)
        cl_periph_pkg::IrqEnableReg:  rd = en_m;
        cl_periph_pkg::IrqPendingReg: rd = pend_m;
        cl_periph_pkg::IrqIdReg:      rd = {27'b0, top_id()};
        default: ;
      endcase
      return {1'b0, rd};
    end
    if (rel >= cl_periph_pkg::DataErrOffset) begin
      n   = data_q.size();
      ovf = data_ovf;
      if (n > 0) head = data_q[0];
    end else begin
      n   = instr_q.size();
      ovf = instr_ovf;
      if (n > 0) head = instr_q[0];
    end
    case (off)
      cl_periph_pkg::ErrAddrReg:   rd = head[31+ErrBits:ErrBits];
      cl_periph_pkg::ErrCodeReg:   rd[ErrBits-1:0] = head[ErrBits-1:0];
      cl_periph_pkg::ErrStatusReg: rd = {ovf, 23'b0, 8'(n)};
      default: ;
    endcase
    return {1'b0, rd};
  endfunction

  function automatic void model_write(cl_periph_pkg::addr_t addr, cl_periph_pkg::data_t wdata);
    cl_periph_pkg::addr_t    rel;
    cl_periph_pkg::reg_off_t off;
    rel = addr - Base;
    off = rel[7:0];
    if (rel >= cl_periph_pkg::IrqOffset + cl_periph_pkg::TgtRange) return;
    if (rel >= cl_periph_pkg::IrqOffset) begin
      if (off == cl_periph_pkg::IrqEnableReg) en_m = wdata;
      else if (off == cl_periph_pkg::IrqPendingReg) pend_m = pend_m & ~wdata;
    end else if (off == cl_periph_pkg::ErrStatusReg) begin
      if (rel >= cl_periph_pkg::DataErrOffset) begin
        if (data_q.size() != 0) void'(data_q.pop_front());
        data_ovf = 1'b0;
      end else begin
        if (instr_q.size() != 0) void'(instr_q.pop_front());
        instr_ovf = 1'b0;
      end
    end
  endfunction

  // A queue going non-empty is a rising interrupt source
  function automatic void model_push(logic is_data, entry_t e);
    if (is_data) begin
      if (data_q.size() == 0) pend_m[cl_periph_pkg::DataErrIrqIdx] = 1'b1;
      if (data_q.size() < Depth) data_q.push_back(e);
      else data_ovf = 1'b1;
    end else begin
      if (instr_q.size() == 0) pend_m[cl_periph_pkg::InstrErrIrqIdx] = 1'b1;
      if (instr_q.size() < Depth) instr_q.push_back(e);
      else instr_ovf = 1'b1;
    end
  endfunction

  function automatic logic [ErrBits-1:0] rand_code(logic force_fail);
    logic [31:0]        r;
    logic [ErrBits-1:0] code;
    r    = $random(seed);
    code = r[ErrBits-1:0];
    if (force_fail && code == '0) code = 1;
    return code;
  endfunction

  function automatic void report_mismatch(string what, logic [32:0] exp, logic [32:0] act);
    err_count++;
    $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
  endfunction

  // Response checker, one cycle after each request
  always @(negedge clk) begin
    if (!rst && reg_rsp.valid) begin
      if (exp_val.size() == 0) begin
        cmp_errs++;
        $display("%s: response without a request", cur_test);
      end else begin
        if (cyc != exp_cyc[0] + 1) begin
          cmp_errs++;
          $display("%s: response to %h came in cycle %0d, request was in cycle %0d",
                   cur_test, exp_addr[0], cyc, exp_cyc[0]);
        end
        if ({reg_rsp.error, reg_rsp.rdata} !== exp_val[0]) begin
          cmp_errs++;
          $display("mismatch %s addr %h expected %h actual %h", cur_test, exp_addr[0],
                   exp_val[0], {reg_rsp.error, reg_rsp.rdata});
        end
        void'(exp_val.pop_front());
        void'(exp_cyc.pop_front());
        void'(exp_addr.pop_front());
      end
    end else if (!rst && exp_val.size() != 0 && cyc > exp_cyc[0] + 1) begin
      cmp_errs++;
      $display("%s: no response to the request at %h", cur_test, exp_addr[0]);
      void'(exp_val.pop_front());
      void'(exp_cyc.pop_front());
      void'(exp_addr.pop_front());
    end
  end

  // Leaves valid high so requests can follow back to back
  task automatic reg_issue(input logic write, input cl_periph_pkg::addr_t addr,
                           input cl_periph_pkg::data_t wdata);
    @(posedge clk);
    #1;
    exp_val.push_back(ref_read(addr));
    exp_cyc.push_back(cyc);
    exp_addr.push_back(addr);
    if (write) model_write(addr, wdata);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
  endtask

  task automatic reg_release();
    @(posedge clk);
    #1;
    reg_req = '0;
  endtask

  task automatic reg_read(input cl_periph_pkg::addr_t addr);
    reg_issue(1'b0, addr, '0);
    reg_release();
  endtask

  task automatic reg_write(input cl_periph_pkg::addr_t addr, input cl_periph_pkg::data_t wdata);
    reg_issue(1'b1, addr, wdata);
    reg_release();
  endtask

  // OBI slave: grant at once, response on the next cycle
  task automatic obi_txn(input logic is_data, input cl_periph_pkg::addr_t addr,
                         input logic [ErrBits-1:0] code);
    @(posedge clk);
    #1;
    if (is_data) begin
      data_req  = 1'b1;
      data_gnt  = 1'b1;
      data_addr = addr;
    end else begin
      instr_req  = 1'b1;
      instr_gnt  = 1'b1;
      instr_addr = addr;
    end
    @(posedge clk);
    #1;
    {instr_req, instr_gnt, data_req, data_gnt} = '0;
    if (is_data) begin
      data_rvalid = 1'b1;
      data_err    = code;
    end else begin
      instr_rvalid = 1'b1;
      instr_err    = code;
    end
    if (code != '0) model_push(is_data, {addr, code});
    @(posedge clk);
    #1;
    {instr_rvalid, data_rvalid} = '0;
    instr_err = '0;
    data_err  = '0;
    repeat (2) @(posedge clk);
  endtask

  task automatic drive_line(input int src, input logic level);
    logic old;
    @(posedge clk);
    #1;
    if (src == cl_periph_pkg::TimerIrqIdx) begin
      old       = timer_irq;
      timer_irq = level;
    end else begin
      old = ext_irqs[src - cl_periph_pkg::ExtIrqBase];
      ext_irqs[src - cl_periph_pkg::ExtIrqBase] = level;
    end
    if (level && !old) pend_m[src] = 1'b1;
    repeat (2) @(posedge clk);
  endtask

  task automatic wait_irq(input int exp_id);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 10 && !seen; i++) begin
      @(negedge clk);
      seen = irq_valid && (irq_id == 5'(exp_id));
    end
    if (!seen) report_mismatch("irq_id_o", 33'(exp_id), {28'b0, irq_id});
  endtask

  task automatic check_irq_valid(input logic exp);
    @(negedge clk);
    if (irq_valid !== exp) report_mismatch("irq_valid_o", 33'(exp), 33'(irq_valid));
  endtask

  // Acknowledge whatever id is shown
  task automatic ack_irq();
    @(posedge clk);
    #1;
    pend_m[top_id()] = 1'b0;
    irq_ack = 1'b1;
    @(posedge clk);
    #1;
    irq_ack = 1'b0;
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    test_start_errs = err_count + cmp_errs;
  endtask

  task automatic end_test();
    int errs;
    repeat (3) @(posedge clk);
    if (exp_val.size() != 0) begin
      err_count++;
      $display("%s: %0d responses never arrived", cur_test, exp_val.size());
      exp_val.delete();
      exp_cyc.delete();
      exp_addr.delete();
    end
    errs = err_count + cmp_errs - test_start_errs;
    if (errs == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errs);
    end
  endtask

  task automatic test_unmapped();
    begin_test("unmapped_decode");
    reg_read(32'h0000_0000);
    reg_read(Base + 32'h300);
    reg_read(Base - 32'h4);
    reg_read(32'hFFFF_FFFC);
    reg_write(Base + 32'h3F0, 32'h1234_5678);
    for (int w = 0; w < 3; w++) begin
      for (int r = 0; r < 4; r++) begin
        reg_read(Base + 32'(w * 256 + r * 4));
      end
    end
    // Back to back, read after write sees the new enables
    reg_issue(1'b1, irq_reg(cl_periph_pkg::IrqEnableReg), 32'h0000_00A5);
    reg_issue(1'b0, irq_reg(cl_periph_pkg::IrqEnableReg), '0);
    reg_issue(1'b0, Base + 32'h400, '0);
    reg_issue(1'b1, irq_reg(cl_periph_pkg::IrqEnableReg), '0);
    reg_issue(1'b0, err_reg(1'b1, cl_periph_pkg::ErrStatusReg), '0);
    reg_release();
    end_test();
  endtask

  task automatic test_instr_errors();
    begin_test("instr_error_queue");
    for (int i = 0; i < 8; i++) begin
      obi_txn(1'b0, 32'h1C00_0000 + 32'(i * 8), rand_code(1'b0));
    end
    reg_read(err_reg(1'b1, cl_periph_pkg::ErrStatusReg));
    reg_read(err_reg(1'b0, cl_periph_pkg::ErrStatusReg));
    while (instr_q.size() != 0) begin
      reg_read(err_reg(1'b0, cl_periph_pkg::ErrAddrReg));
      reg_read(err_reg(1'b0, cl_periph_pkg::ErrCodeReg));
      reg_write(err_reg(1'b0, cl_periph_pkg::ErrStatusReg), '0);
    end
    reg_read(err_reg(1'b0, cl_periph_pkg::ErrStatusReg));
    end_test();
  endtask

  task automatic test_data_overflow();
    begin_test("data_error_overflow");
    for (int i = 0; i < 10; i++) begin
      obi_txn(1'b1, 32'h8000_0100 + 32'(i * 4), rand_code(1'b1));
    end
    // Eight stored, overflow set
    if (ref_read(err_reg(1'b1, cl_periph_pkg::ErrStatusReg)) != {1'b0, 32'h8000_0008}) begin
      report_mismatch("model status", {1'b0, 32'h8000_0008},
                      ref_read(err_reg(1'b1, cl_periph_pkg::ErrStatusReg)));
    end
    reg_read(err_reg(1'b1, cl_periph_pkg::ErrStatusReg));
    reg_read(err_reg(1'b0, cl_periph_pkg::ErrStatusReg));
    for (int i = 0; i < 8; i++) begin
      reg_read(err_reg(1'b1, cl_periph_pkg::ErrAddrReg));
      reg_read(err_reg(1'b1, cl_periph_pkg::ErrCodeReg));
      reg_write(err_reg(1'b1, cl_periph_pkg::ErrStatusReg), '0);
    end
    reg_read(err_reg(1'b1, cl_periph_pkg::ErrStatusReg));
    end_test();
  endtask

  task automatic test_irq_priority();
    begin_test("irq_priority_ack");
    reg_write(irq_reg(cl_periph_pkg::IrqPendingReg), 32'hFFFF_FFFF);
    reg_write(irq_reg(cl_periph_pkg::IrqEnableReg),
              (32'h1 << cl_periph_pkg::InstrErrIrqIdx) | 32'hFF00_0000);
    check_irq_valid(1'b0);
    obi_txn(1'b0, 32'h1C00_0400, rand_code(1'b1));
    wait_irq(cl_periph_pkg::InstrErrIrqIdx);
    drive_line(cl_periph_pkg::ExtIrqBase + 3, 1'b1);
    wait_irq(cl_periph_pkg::ExtIrqBase + 3);
    reg_read(irq_reg(cl_periph_pkg::IrqIdReg));
    ack_irq();
    wait_irq(cl_periph_pkg::InstrErrIrqIdx);
    ack_irq();
    check_irq_valid(1'b0);
    reg_read(irq_reg(cl_periph_pkg::IrqPendingReg));
    drive_line(cl_periph_pkg::ExtIrqBase + 3, 1'b0);
    reg_write(err_reg(1'b0, cl_periph_pkg::ErrStatusReg), '0);
    end_test();
  endtask

  task automatic test_irq_disabled();
    begin_test("irq_disabled_source");
    drive_line(cl_periph_pkg::TimerIrqIdx, 1'b1);
    check_irq_valid(1'b0);
    reg_read(irq_reg(cl_periph_pkg::IrqPendingReg));
    reg_write(irq_reg(cl_periph_pkg::IrqEnableReg), en_m | (32'h1 << cl_periph_pkg::TimerIrqIdx));
    wait_irq(cl_periph_pkg::TimerIrqIdx);
    reg_read(irq_reg(cl_periph_pkg::IrqIdReg));
    reg_write(irq_reg(cl_periph_pkg::IrqPendingReg), 32'h1 << cl_periph_pkg::TimerIrqIdx);
    repeat (2) @(posedge clk);
    check_irq_valid(1'b0);
    reg_read(irq_reg(cl_periph_pkg::IrqPendingReg));
    drive_line(cl_periph_pkg::TimerIrqIdx, 1'b0);
    end_test();
  endtask

  initial begin
    seed = 32'he3ae_e989;
    rst  = 1'b1;
    reg_req = '0;
    {instr_req, instr_gnt, instr_rvalid} = '0;
    {data_req, data_gnt, data_rvalid} = '0;
    instr_addr = '0;
    instr_err  = '0;
    data_addr  = '0;
    data_err   = '0;
    timer_irq  = 1'b0;
    ext_irqs   = '0;
    irq_ack    = 1'b0;
    instr_ovf  = 1'b0;
    data_ovf   = 1'b0;
    pend_m     = '0;
    en_m       = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    test_unmapped();
    test_instr_errors();
    test_data_overflow();
    test_irq_priority();
    test_irq_disabled();
    $display("%0d of %0d tests failed, %0d errors in total", tests_failed, NumTests,
             err_count + cmp_errs);
    if (err_count + cmp_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    repeat (CyclesPerTest * NumTests) @(posedge clk);
    $display("watchdog expired after %0d cycles in test %s", CyclesPerTest * NumTests, cur_test);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
cl_periph_pkg.sv
cl_periph_decode.sv
obi_err_unit.sv
irq_ctrl.sv
safety_periph_top.sv
tb_safety_periph.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_safety_periph \
  -f src.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0
